// ==== logic/dmmu_macros.svh ====
/*
 * Data MMU sizing
 * Address field widths, TLB depth, domain id width and the
 * privilege mode encodings shared by the translation path
 */
`ifndef DMMU_MACROS_SVH
`define DMMU_MACROS_SVH

`define DMMU_VTAG_WIDTH        27
`define DMMU_PAGE_OFFSET_WIDTH 12
`define DMMU_PTAG_WIDTH        28
`define DMMU_DID_WIDTH         3
`define DMMU_TLB_ELS           8

`define DMMU_VADDR_WIDTH (`DMMU_VTAG_WIDTH + `DMMU_PAGE_OFFSET_WIDTH)
`define DMMU_PADDR_WIDTH (`DMMU_PTAG_WIDTH + `DMMU_PAGE_OFFSET_WIDTH)

// RISC-V privilege levels
`define DMMU_PRIV_WIDTH 2
`define DMMU_PRIV_U     2'd0
`define DMMU_PRIV_S     2'd1
`define DMMU_PRIV_M     2'd3

`endif

// ==== logic/dmmu_top.sv ====
/*
 * Data address translation path
 * TLB lookup, stage register and fault check in a two-cycle
 * pipeline from command strobe to response
 */
`timescale 1ns/1ps
`include "dmmu_macros.svh"

module dmmu_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          cmd_v_i,
  input  mmu_op_pkg::mem_op_e           cmd_op_i,
  input  logic [`DMMU_VADDR_WIDTH-1:0]  cmd_vaddr_i,
  input  logic                          translation_en_i,
  input  mmu_pte_pkg::priv_mode_e       priv_mode_i,
  input  logic                          sum_i,
  input  logic                          flush_i,
  input  logic                          fill_v_i,
  input  logic [`DMMU_VTAG_WIDTH-1:0]   fill_vtag_i,
  input  mmu_pte_pkg::pte_leaf_s        fill_entry_i,
  input  logic                          poison_i,
  output logic                          resp_v_o,
  output mmu_op_pkg::fault_e            resp_fault_o,
  output logic [`DMMU_PADDR_WIDTH-1:0]  resp_paddr_o
);
  import mmu_pte_pkg::*;
  import mmu_op_pkg::*;

  logic                               tlb_v, tlb_hit, held_v, held_hit;
  mem_op_e                            tlb_op, held_op;
  pte_leaf_s                          tlb_entry, held_entry;
  logic [`DMMU_PAGE_OFFSET_WIDTH-1:0] page_offset_r, held_page_offset;

  // Offset lines up with the registered TLB result
  always_ff @(posedge clk_i) begin
    page_offset_r <= cmd_vaddr_i[`DMMU_PAGE_OFFSET_WIDTH-1:0];
  end

  dtlb u_dtlb (
    .clk_i(clk_i), .reset_i(reset_i), .flush_i(flush_i),
    .translation_en_i(translation_en_i),
    .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i),
    .cmd_vtag_i(cmd_vaddr_i[`DMMU_VADDR_WIDTH-1 -: `DMMU_VTAG_WIDTH]),
    .fill_v_i(fill_v_i), .fill_vtag_i(fill_vtag_i), .fill_entry_i(fill_entry_i),
    .v_o(tlb_v), .op_o(tlb_op), .hit_o(tlb_hit), .entry_o(tlb_entry)
  );

  xlate_stage_reg u_stage (
    .clk_i(clk_i), .reset_i(reset_i), .poison_i(poison_i),
    .v_i(tlb_v), .op_i(tlb_op), .hit_i(tlb_hit), .entry_i(tlb_entry),
    .page_offset_i(page_offset_r),
    .v_o(held_v), .op_o(held_op), .hit_o(held_hit), .entry_o(held_entry),
    .page_offset_o(held_page_offset)
  );

  fault_check u_check (
    .v_i(held_v), .op_i(held_op), .hit_i(held_hit), .entry_i(held_entry),
    .page_offset_i(held_page_offset), .translation_en_i(translation_en_i),
    .priv_mode_i(priv_mode_i), .sum_i(sum_i),
    .resp_v_o(resp_v_o), .resp_fault_o(resp_fault_o), .resp_paddr_o(resp_paddr_o)
  );

endmodule

// ==== logic/dtlb.sv ====
/*
 * Data TLB
 * Fully associative table with fill and flush, round-robin
 * replacement and a registered lookup. With translation off the
 * lookup returns an identity mapping that always hits.
 */
`timescale 1ns/1ps
`include "dmmu_macros.svh"

module dtlb (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         flush_i,
  input  logic                         translation_en_i,
  input  logic                         cmd_v_i,
  input  mmu_op_pkg::mem_op_e          cmd_op_i,
  input  logic [`DMMU_VTAG_WIDTH-1:0]  cmd_vtag_i,
  input  logic                         fill_v_i,
  input  logic [`DMMU_VTAG_WIDTH-1:0]  fill_vtag_i,
  input  mmu_pte_pkg::pte_leaf_s       fill_entry_i,
  output logic                         v_o,
  output mmu_op_pkg::mem_op_e          op_o,
  output logic                         hit_o,
  output mmu_pte_pkg::pte_leaf_s       entry_o
);
  import mmu_pte_pkg::*;

  localparam int unsigned idx_width_lp = $clog2(`DMMU_TLB_ELS);

  logic [`DMMU_TLB_ELS-1:0]    valid_r;
  logic [`DMMU_VTAG_WIDTH-1:0] tag_r [`DMMU_TLB_ELS];
  pte_leaf_s                   entry_r [`DMMU_TLB_ELS];
  logic [idx_width_lp-1:0]     victim_r;

  logic [`DMMU_TLB_ELS-1:0] lookup_match;
  logic [`DMMU_TLB_ELS-1:0] fill_match;
  logic [idx_width_lp-1:0]  fill_idx;
  pte_leaf_s                hit_entry;
  pte_leaf_s                identity_entry;

  always_comb begin
    hit_entry = '0;
    fill_idx = victim_r;
    for (int i = 0; i < `DMMU_TLB_ELS; i++) begin
      lookup_match[i] = valid_r[i] && (tag_r[i] == cmd_vtag_i);
      fill_match[i] = valid_r[i] && (tag_r[i] == fill_vtag_i);
      if (lookup_match[i]) begin
        hit_entry = hit_entry | entry_r[i];
      end
      // Refill of a present tag overwrites it in place
      if (fill_match[i]) begin
        fill_idx = idx_width_lp'(i);
      end
    end
  end

  always_comb begin
    identity_entry = '0;
    identity_entry.ptag = {{(`DMMU_PTAG_WIDTH-`DMMU_VTAG_WIDTH){1'b0}}, cmd_vtag_i};
    identity_entry.u = 1'b1;
    identity_entry.w = 1'b1;
    identity_entry.d = 1'b1;
    identity_entry.a = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      victim_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_idx] <= 1'b1;
      if (~|fill_match) begin
        victim_r <= victim_r + idx_width_lp'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx] <= fill_vtag_i;
      entry_r[fill_idx] <= fill_entry_i;
    end
  end

  // Lookup result, first pipeline stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_o <= cmd_op_i;
    hit_o <= ~translation_en_i | (|lookup_match);
    entry_o <= translation_en_i ? hit_entry : identity_entry;
  end

  // Fills never leave two valid copies of a tag
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(lookup_match))
    else $error("dtlb: more than one entry matches the lookup tag");

endmodule

// ==== logic/fault_check.sv ====
/*
 * Translation fault check
 * Combinational response stage. Applies the privilege, write
 * permission and domain checks to the held translation and
 * forms the physical address and fault code.
 */
`timescale 1ns/1ps
`include "dmmu_macros.svh"

module fault_check (
  input  logic                                v_i,
  input  mmu_op_pkg::mem_op_e                 op_i,
  input  logic                                hit_i,
  input  mmu_pte_pkg::pte_leaf_s              entry_i,
  input  logic [`DMMU_PAGE_OFFSET_WIDTH-1:0]  page_offset_i,
  input  logic                                translation_en_i,
  input  mmu_pte_pkg::priv_mode_e             priv_mode_i,
  input  logic                                sum_i,
  output logic                                resp_v_o,
  output mmu_op_pkg::fault_e                  resp_fault_o,
  output logic [`DMMU_PADDR_WIDTH-1:0]        resp_paddr_o
);
  import mmu_pte_pkg::*;
  import mmu_op_pkg::*;

  logic priv_fault;
  logic write_fault;
  logic did_fault;

  // S-mode needs SUM to touch user pages; U-mode never sees S pages
  assign priv_fault = translation_en_i
                    & (((priv_mode_i == priv_s) & ~sum_i & entry_i.u)
                      | ((priv_mode_i == priv_u) & ~entry_i.u));

  assign write_fault = (op_i == op_store) & (~entry_i.w | ~entry_i.d);

  // Only domain 0 is reachable
  assign did_fault = |entry_i.ptag[`DMMU_PTAG_WIDTH-1 -: `DMMU_DID_WIDTH];

  assign resp_v_o = v_i;
  assign resp_paddr_o = {entry_i.ptag, page_offset_i};

  always_comb begin
    if (!v_i) begin
      resp_fault_o = fault_none;
    end else if (!hit_i) begin
      resp_fault_o = fault_miss;
    end else if (priv_fault | write_fault) begin
      resp_fault_o = page_fault_of(op_i);
    end else if (did_fault) begin
      resp_fault_o = access_fault_of(op_i);
    end else begin
      resp_fault_o = fault_none;
    end
  end

endmodule

// ==== logic/mmu_op_pkg.sv ====
/*
 * Memory operation types
 * Load/store command encoding and the fault codes returned
 * with every translation response
 */
package mmu_op_pkg;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    fault_none,
    fault_miss,
    fault_load_page,
    fault_store_page,
    fault_load_access,
    fault_store_access
  } fault_e;

  function automatic fault_e page_fault_of(mem_op_e op);
    return (op == op_store) ? fault_store_page : fault_load_page;
  endfunction

  function automatic fault_e access_fault_of(mem_op_e op);
    return (op == op_store) ? fault_store_access : fault_load_access;
  endfunction

endpackage

// ==== logic/mmu_pte_pkg.sv ====
/*
 * Page table entry types
 * Leaf entry as held in the TLB, and the privilege mode
 * of the hart issuing the access
 */
`include "dmmu_macros.svh"

package mmu_pte_pkg;

  typedef enum logic [`DMMU_PRIV_WIDTH-1:0] {
    priv_u = `DMMU_PRIV_U,
    priv_s = `DMMU_PRIV_S,
    priv_m = `DMMU_PRIV_M
  } priv_mode_e;

  // Only the leaf bits the data path needs
  typedef struct packed {
    logic [`DMMU_PTAG_WIDTH-1:0] ptag;
    // User accessible
    logic u;
    logic w;
    // Dirty
    logic d;
    logic a;
  } pte_leaf_s;

endpackage

// ==== logic/xlate_stage_reg.sv ====
/*
 * Translation stage register
 * Second pipeline stage. Holds one translated command with its
 * page offset and drops it when the item is poisoned.
 */
`timescale 1ns/1ps
`include "dmmu_macros.svh"

module xlate_stage_reg (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                poison_i,
  input  logic                                v_i,
  input  mmu_op_pkg::mem_op_e                 op_i,
  input  logic                                hit_i,
  input  mmu_pte_pkg::pte_leaf_s              entry_i,
  input  logic [`DMMU_PAGE_OFFSET_WIDTH-1:0]  page_offset_i,
  output logic                                v_o,
  output mmu_op_pkg::mem_op_e                 op_o,
  output logic                                hit_o,
  output mmu_pte_pkg::pte_leaf_s              entry_o,
  output logic [`DMMU_PAGE_OFFSET_WIDTH-1:0]  page_offset_o
);

  // Poison kills the item already in flight from the TLB stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i & ~poison_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_o <= op_i;
    hit_o <= hit_i;
    entry_o <= entry_i;
    page_offset_o <= page_offset_i;
  end

  // A live item must carry a fully known translation
  assert property (@(posedge clk_i) disable iff (reset_i)
                   v_o |-> !$isunknown({op_o, hit_o, entry_o, page_offset_o}))
    else $error("xlate_stage_reg: valid item with unknown payload");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data MMU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -f verilog.f --top-module dmmu_tb -o dmmu_sim

# The log decides the result, so a non-zero simulator exit is not fatal here
./obj_dir/dmmu_sim > sim.log 2>&1 || true

cat sim.log

if grep -q "All tests passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== testbench/dmmu_tb.sv ====
/*
 * Data MMU testbench
 * Fills the TLB, then runs a table of load and store commands
 * through the translation path and checks each response
 * against the expected fault code and physical address.
 */
`timescale 1ns/1ps
`include "dmmu_macros.svh"

module dmmu_tb;
  import mmu_pte_pkg::*;
  import mmu_op_pkg::*;

  typedef struct packed {
    logic                           ten;
    priv_mode_e                     priv;
    logic                           sum;
    mem_op_e                        op;
    logic [`DMMU_VADDR_WIDTH-1:0]   vaddr;
    logic                           poison;
    logic                           flush;
    fault_e                         fault;
    logic [`DMMU_PADDR_WIDTH-1:0]   paddr;
  } row_s;

  typedef struct packed {
    fault_e                         fault;
    logic [`DMMU_PADDR_WIDTH-1:0]   paddr;
  } expect_s;

  logic                           clk_i, reset_i, cmd_v_i, translation_en_i, sum_i;
  logic                           flush_i, fill_v_i, poison_i, resp_v_o;
  mem_op_e                        cmd_op_i;
  priv_mode_e                     priv_mode_i;
  logic [`DMMU_VADDR_WIDTH-1:0]   cmd_vaddr_i;
  logic [`DMMU_VTAG_WIDTH-1:0]    fill_vtag_i;
  pte_leaf_s                      fill_entry_i;
  fault_e                         resp_fault_o;
  logic [`DMMU_PADDR_WIDTH-1:0]   resp_paddr_o;

  row_s    rows[$];
  expect_s exp_q[$];
  expect_s exp_item;
  logic    pend_poison;
  int      fault_errs, paddr_errs, other_errs;

  dmmu_top u_dut (
    .clk_i(clk_i), .reset_i(reset_i), .cmd_v_i(cmd_v_i), .cmd_op_i(cmd_op_i),
    .cmd_vaddr_i(cmd_vaddr_i), .translation_en_i(translation_en_i),
    .priv_mode_i(priv_mode_i), .sum_i(sum_i), .flush_i(flush_i),
    .fill_v_i(fill_v_i), .fill_vtag_i(fill_vtag_i), .fill_entry_i(fill_entry_i),
    .poison_i(poison_i), .resp_v_o(resp_v_o), .resp_fault_o(resp_fault_o),
    .resp_paddr_o(resp_paddr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic add_row(input logic ten, input priv_mode_e priv, input logic sum,
                         input mem_op_e op, input logic [`DMMU_VTAG_WIDTH-1:0] vtag,
                         input logic [`DMMU_PAGE_OFFSET_WIDTH-1:0] off,
                         input logic poison, input logic flush, input fault_e fault,
                         input logic [`DMMU_PTAG_WIDTH-1:0] ptag);
    row_s r;
    r.ten = ten;
    r.priv = priv;
    r.sum = sum;
    r.op = op;
    r.vaddr = {vtag, off};
    r.poison = poison;
    r.flush = flush;
    r.fault = fault;
    r.paddr = {ptag, off};
    rows.push_back(r);
  endtask

  task automatic fill_page(input logic [`DMMU_VTAG_WIDTH-1:0] vtag,
                           input logic [`DMMU_PTAG_WIDTH-1:0] ptag,
                           input logic u, input logic w, input logic d);
    @(posedge clk_i);
    fill_v_i <= 1'b1;
    fill_vtag_i <= vtag;
    fill_entry_i <= {ptag, u, w, d, 1'b1};
  endtask

  // Poison for the previous command goes out one cycle after it
  task automatic idle_cycle();
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    poison_i <= pend_poison;
    pend_poison = 1'b0;
  endtask

  task automatic issue_row(input row_s r);
    expect_s e;
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_op_i <= r.op;
    cmd_vaddr_i <= r.vaddr;
    translation_en_i <= r.ten;
    priv_mode_i <= r.priv;
    sum_i <= r.sum;
    poison_i <= pend_poison;
    pend_poison = r.poison;
    if (!r.poison) begin
      e.fault = r.fault;
      e.paddr = r.paddr;
      exp_q.push_back(e);
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    idle_cycle();
    while (exp_q.size() != 0 && cnt < 16) begin
      idle_cycle();
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: no response came for %0d pending command(s)", exp_q.size());
      other_errs++;
      exp_q.delete();
    end
  endtask

  task automatic pulse_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  function automatic logic config_differs(input row_s a, input row_s b);
    return (a.ten != b.ten) || (a.priv != b.priv) || (a.sum != b.sum);
  endfunction

  always @(negedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      if (exp_q.size() == 0) begin
        $display("Response came at %0t with no command outstanding", $time);
        other_errs++;
      end else begin
        exp_item = exp_q.pop_front();
        if (resp_fault_o != exp_item.fault) begin
          $display("error at %0t: fault %s, expected %s", $time,
                   resp_fault_o.name(), exp_item.fault.name());
          fault_errs++;
        end
        // Physical address is undefined on a miss
        if (exp_item.fault != fault_miss && resp_paddr_o != exp_item.paddr) begin
          $display("error at %0t: paddr %h, expected %h", $time,
                   resp_paddr_o, exp_item.paddr);
          paddr_errs++;
        end
      end
    end
  end

  initial begin
    reset_i <= 1'b1;
    cmd_v_i <= 1'b0;
    cmd_op_i <= op_load;
    cmd_vaddr_i <= '0;
    translation_en_i <= 1'b0;
    priv_mode_i <= priv_s;
    sum_i <= 1'b0;
    flush_i <= 1'b0;
    fill_v_i <= 1'b0;
    fill_vtag_i <= '0;
    fill_entry_i <= '0;
    poison_i <= 1'b0;
    pend_poison = 1'b0;
    fault_errs = 0;
    paddr_errs = 0;
    other_errs = 0;

    // ten priv sum op vtag offset poison flush fault ptag
    add_row(1, priv_s, 0, op_load, 27'h0000101, 12'h123, 0, 0, fault_none, 28'h00A0B0C);
    add_row(1, priv_s, 0, op_load, 27'h0000999, 12'h004, 0, 0, fault_miss, 28'h0);
    add_row(1, priv_s, 0, op_load, 27'h0000202, 12'h040, 0, 0, fault_load_page, 28'h0123456);
    add_row(1, priv_s, 0, op_load, 27'h0000505, 12'h008, 0, 0, fault_load_access, 28'hA000055);
    add_row(1, priv_s, 0, op_store, 27'h0000505, 12'h00C, 0, 0, fault_store_access, 28'hA000055);
    add_row(1, priv_s, 0, op_load, 27'h0000101, 12'h200, 1, 0, fault_none, 28'h00A0B0C);
    add_row(1, priv_s, 0, op_load, 27'h0000101, 12'hFFF, 0, 0, fault_none, 28'h00A0B0C);
    add_row(1, priv_s, 1, op_load, 27'h0000202, 12'h044, 0, 0, fault_none, 28'h0123456);
    add_row(1, priv_u, 0, op_store, 27'h0000202, 12'h3F0, 0, 0, fault_none, 28'h0123456);
    add_row(1, priv_u, 0, op_load, 27'h0000101, 12'h010, 0, 0, fault_load_page, 28'h00A0B0C);
    add_row(1, priv_u, 0, op_store, 27'h0000303, 12'h020, 0, 0, fault_store_page, 28'h0033330);
    add_row(1, priv_u, 0, op_store, 27'h0000404, 12'h030, 0, 0, fault_store_page, 28'h0044440);
    add_row(1, priv_u, 0, op_load, 27'h0000303, 12'h024, 0, 0, fault_none, 28'h0033330);
    add_row(1, priv_u, 0, op_store, 27'h0000101, 12'h018, 0, 0, fault_store_page, 28'h00A0B0C);
    add_row(0, priv_u, 0, op_load, 27'h0000101, 12'h010, 0, 0, fault_none, 28'h0000101);
    add_row(0, priv_u, 0, op_store, 27'h6000001, 12'h0A0, 0, 0, fault_store_access, 28'h6000001);
    add_row(0, priv_u, 0, op_load, 27'h0000999, 12'h555, 0, 0, fault_none, 28'h0000999);
    add_row(0, priv_s, 0, op_load, 27'h0000404, 12'h0F0, 0, 0, fault_none, 28'h0000404);
    add_row(0, priv_u, 0, op_store, 27'h0000303, 12'h777, 1, 0, fault_none, 28'h0000303);
    add_row(1, priv_s, 0, op_load, 27'h0000101, 12'h123, 0, 1, fault_miss, 28'h0);
    add_row(1, priv_s, 0, op_load, 27'h0000202, 12'h040, 0, 0, fault_miss, 28'h0);

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // S page, U pages (rw, read-only, clean) and an S page outside domain 0
    fill_page(27'h0000101, 28'h00A0B0C, 1'b0, 1'b1, 1'b1);
    fill_page(27'h0000202, 28'h0123456, 1'b1, 1'b1, 1'b1);
    fill_page(27'h0000303, 28'h0033330, 1'b1, 1'b0, 1'b1);
    fill_page(27'h0000404, 28'h0044440, 1'b1, 1'b1, 1'b0);
    fill_page(27'h0000505, 28'hA000055, 1'b0, 1'b1, 1'b1);
    @(posedge clk_i);
    fill_v_i <= 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      if (i == 0 || rows[i].flush || config_differs(rows[i], rows[i-1])) begin
        wait_drain();
        if (rows[i].flush) begin
          pulse_flush();
        end
      end
      issue_row(rows[i]);
    end
    wait_drain();
    repeat (4) idle_cycle();

    $display("Errors: %0d fault, %0d paddr, %0d other", fault_errs, paddr_errs, other_errs);
    if (fault_errs + paddr_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/mmu_pte_pkg.sv
logic/mmu_op_pkg.sv
logic/dtlb.sv
logic/xlate_stage_reg.sv
logic/fault_check.sv
logic/dmmu_top.sv
testbench/dmmu_tb.sv
